// ==== common/cgmii_pkg.sv ====
package cgmii_pkg;

    //**********************************************************************
    // bus geometry
    //**********************************************************************
    localparam int CGMII_DATA_W = 256;              // full width receive bus
    localparam int LANE_W       = 8;                // one byte per lane

    // starts are legal only on 4-lane boundaries
    localparam int SOF_ALIGN    = 4;

    //**********************************************************************
    // control characters
    //**********************************************************************
    localparam logic [LANE_W-1:0] CHAR_START = 8'hFB;   // /S/
    localparam logic [LANE_W-1:0] CHAR_TERM  = 8'hFD;   // /T/

    //**********************************************************************
    // 25G sampling
    //**********************************************************************
    localparam int PHASE_W = 2;                     // four clocks per beat

    // phase that carries the new beat
    localparam logic [PHASE_W-1:0] SAMPLE_PHASE = 2'd2;

endpackage

// ==== common/mac_reg_pkg.sv ====
package mac_reg_pkg;

    //**********************************************************************
    // register bus
    //**********************************************************************
    localparam int REG_ADDR_W = 16;
    localparam int REG_DATA_W = 32;

    // register map
    localparam logic [REG_ADDR_W-1:0] ADDR_BAD_FRAME_CNT = 16'h0040;
    localparam logic [REG_ADDR_W-1:0] ADDR_RX_STATUS     = 16'h0044;

    //**********************************************************************
    // control word fields
    //**********************************************************************
    localparam int CTRL_RX_AUTO_CLR_BIT = 7;        // fmac_ctrl rx auto clear

    // counter sits below the misaligned start sticky bit
    localparam int BAD_CNT_W = 31;

    // start strobe to done pulse, in clocks
    localparam int READ_LATENCY = 5;

endpackage

// ==== files.f ====
common/cgmii_pkg.sv
common/mac_reg_pkg.sv
frame_check/beat_phase_counter.sv
frame_check/lane_scan.sv
frame_check/frame_tracker.sv
frame_check/bad_frame_counter.sv
src/reg_read_port.sv
src/rx_frame_check_top.sv
tests/tb_clock_gen.sv
tests/rx_frame_check_tb.sv

// ==== frame_check/bad_frame_counter.sv ====
`timescale 1ns/100ps

module bad_frame_counter
    import mac_reg_pkg::*;
(
    input  logic                  xA_clk,
    input  logic                  reset_,
    input  logic                  bad_frame,
    input  logic                  misaligned_sticky,
    input  logic                  fmac_rxd_en,
    input  logic                  rx_auto_clr,
    output logic [REG_DATA_W-1:0] bad_frame_reg
);

    logic                 rxd_en_q;
    logic [BAD_CNT_W-1:0] bad_cnt;

    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            rxd_en_q <= 1'b0;
            bad_cnt  <= '0;
        end else begin
            rxd_en_q <= fmac_rxd_en;
            if (!rxd_en_q) begin
                bad_cnt <= '0;                      // restart from zero on enable
            end else if (bad_frame) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

    // sticky misaligned start bit over the count
    assign bad_frame_reg = (rx_auto_clr || !fmac_rxd_en) ? '0 : {misaligned_sticky, bad_cnt};

endmodule

// ==== frame_check/beat_phase_counter.sv ====
`timescale 1ns/100ps

module beat_phase_counter
    import cgmii_pkg::*;
(
    input  logic xA_clk,
    input  logic reset_,
    input  logic mode_25g,
    output logic beat_valid         // high on clocks that carry a new beat
);

    logic               mode_25g_q;
    logic [PHASE_W-1:0] phase;

    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            mode_25g_q <= 1'b0;
            phase      <= '0;
        end else begin
            mode_25g_q <= mode_25g;                             // rebuffer mode pin
            phase      <= mode_25g_q ? phase + 1'b1 : '0;       // free running in 25G
        end
    end

    // full rate samples every clock
    assign beat_valid = !mode_25g_q || (phase == SAMPLE_PHASE);

endmodule

// ==== frame_check/frame_tracker.sv ====
`timescale 1ns/100ps

module frame_tracker (
    input  logic xA_clk,
    input  logic reset_,
    input  logic beat_sof_valid,
    input  logic beat_sof_misaligned,
    input  logic beat_eof,
    output logic bad_frame,             // one clock per badly framed frame
    output logic in_frame,
    output logic misaligned_sticky
);

    typedef enum logic {
        CLOSED = 1'b0,
        OPEN   = 1'b1
    } frame_state_t;

    frame_state_t state;
    logic         any_sof;

    assign any_sof = beat_sof_valid || beat_sof_misaligned;

    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            state             <= CLOSED;
            bad_frame         <= 1'b0;
            misaligned_sticky <= 1'b0;
        end else begin
            // a valid start wins over a terminate in the same beat
            if (beat_sof_valid) begin
                state <= OPEN;
            end else if (beat_eof) begin
                state <= CLOSED;
            end

            bad_frame <= (beat_eof && state == CLOSED) ||               // no start
                         (any_sof && state == OPEN && !beat_eof);       // no terminate

            if (beat_sof_misaligned) begin
                misaligned_sticky <= 1'b1;          // held until reset
            end
        end
    end

    assign in_frame = (state == OPEN);

endmodule

// ==== frame_check/lane_scan.sv ====
`timescale 1ns/100ps

module lane_scan
    import cgmii_pkg::*;
#(
    parameter int DATA_WIDTH = CGMII_DATA_W
) (
    input  logic                         xA_clk,
    input  logic                         reset_,
    input  logic                         beat_valid,
    input  logic [DATA_WIDTH-1:0]        cgmii_rxd,
    input  logic [DATA_WIDTH/LANE_W-1:0] cgmii_rxc,
    output logic                         beat_sof_valid,
    output logic                         beat_sof_misaligned,
    output logic                         beat_eof
);

    localparam int LANES = DATA_WIDTH / LANE_W;

    logic [DATA_WIDTH-1:0] rxd_q;
    logic [LANES-1:0]      rxc_q;
    logic                  sof_aligned_any;
    logic                  sof_misaligned_any;
    logic                  eof_any;

    //**********************************************************************
    // input register
    //**********************************************************************
    always_ff @(posedge xA_clk) begin
        rxd_q <= cgmii_rxd;                 // lane bytes
    end

    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            rxc_q <= '0;
        end else begin
            rxc_q <= cgmii_rxc;
        end
    end

    //**********************************************************************
    // per lane character match, ORed over the beat
    //**********************************************************************
    always_comb begin
        sof_aligned_any    = 1'b0;
        sof_misaligned_any = 1'b0;
        eof_any            = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (rxc_q[i] && rxd_q[i*LANE_W +: LANE_W] == CHAR_START) begin
                if (i % SOF_ALIGN == 0) begin
                    sof_aligned_any = 1'b1;         // lane 0, 4, 8 ...
                end else begin
                    sof_misaligned_any = 1'b1;
                end
            end
            if (rxc_q[i] && rxd_q[i*LANE_W +: LANE_W] == CHAR_TERM) begin
                eof_any = 1'b1;                     // any lane may terminate
            end
        end
    end

    // flags only live for sampled beats
    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            beat_sof_valid      <= 1'b0;
            beat_sof_misaligned <= 1'b0;
            beat_eof            <= 1'b0;
        end else begin
            beat_sof_valid      <= beat_valid && sof_aligned_any;
            beat_sof_misaligned <= beat_valid && sof_misaligned_any;
            beat_eof            <= beat_valid && eof_any;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module rx_frame_check_tb -f files.f \
    -o rx_frame_check_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rx_frame_check_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported errors"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0

// ==== src/reg_read_port.sv ====
`timescale 1ns/100ps

module reg_read_port
    import mac_reg_pkg::*;
#(
    parameter int READ_LATENCY = mac_reg_pkg::READ_LATENCY
) (
    input  logic                  xA_clk,
    input  logic                  reset_,
    input  logic [REG_DATA_W-1:0] fmac_ctrl,
    input  logic                  reg_rd_start,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic [REG_DATA_W-1:0] bad_frame_reg,
    input  logic                  in_frame,
    input  logic                  misaligned_sticky,
    output logic                  rx_auto_clr,
    output logic                  reg_rd_done,
    output logic [REG_DATA_W-1:0] reg_rdata
);

    // last stage of the line is the done register itself
    localparam int DEPTH = READ_LATENCY - 1;

    logic [DEPTH-1:0]      start_pipe;
    logic [REG_ADDR_W-1:0] addr_pipe [DEPTH];
    logic [REG_DATA_W-1:0] rd_mux;

    //**********************************************************************
    // read delay line, one slot per read in flight
    //**********************************************************************
    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            start_pipe <= '0;
        end else begin
            start_pipe[0] <= reg_rd_start;
            for (int i = 1; i < DEPTH; i++) begin
                start_pipe[i] <= start_pipe[i-1];
            end
        end
    end

    always_ff @(posedge xA_clk) begin
        addr_pipe[0] <= reg_addr;                   // address rides with its strobe
        for (int i = 1; i < DEPTH; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    // decode at the point the read completes
    always_comb begin
        case (addr_pipe[DEPTH-1])
            ADDR_BAD_FRAME_CNT: rd_mux = bad_frame_reg;
            ADDR_RX_STATUS:     rd_mux = {{(REG_DATA_W-2){1'b0}}, misaligned_sticky, in_frame};
            default:            rd_mux = '0;        // unmapped
        endcase
    end

    always_ff @(posedge xA_clk) begin
        if (!reset_) begin
            rx_auto_clr <= 1'b0;
            reg_rd_done <= 1'b0;
            reg_rdata   <= '0;
        end else begin
            rx_auto_clr <= fmac_ctrl[CTRL_RX_AUTO_CLR_BIT];
            reg_rd_done <= start_pipe[DEPTH-1];
            if (start_pipe[DEPTH-1]) begin
                reg_rdata <= rd_mux;                // held until the next done
            end
        end
    end

endmodule

// ==== src/rx_frame_check_top.sv ====
`timescale 1ns/100ps

module rx_frame_check_top
    import cgmii_pkg::*;
    import mac_reg_pkg::*;
#(
    parameter int DATA_WIDTH   = CGMII_DATA_W,
    parameter int READ_LATENCY = mac_reg_pkg::READ_LATENCY
) (
    input  logic                         xA_clk,
    input  logic                         reset_,
    input  logic                         mode_25g,      // one beat every four clocks
    input  logic [DATA_WIDTH-1:0]        cgmii_rxd,
    input  logic [DATA_WIDTH/LANE_W-1:0] cgmii_rxc,
    input  logic                         fmac_rxd_en,
    input  logic [REG_DATA_W-1:0]        fmac_ctrl,
    input  logic                         reg_rd_start,
    input  logic [REG_ADDR_W-1:0]        reg_addr,
    output logic                         reg_rd_done,
    output logic [REG_DATA_W-1:0]        reg_rdata
);

    logic                  beat_valid;
    logic                  beat_sof_valid;
    logic                  beat_sof_misaligned;
    logic                  beat_eof;
    logic                  bad_frame;
    logic                  in_frame;
    logic                  misaligned_sticky;
    logic                  rx_auto_clr;
    logic [REG_DATA_W-1:0] bad_frame_reg;

    //**********************************************************************
    // frame check pipeline
    //**********************************************************************
    beat_phase_counter beat_phase_counter_i (
        .xA_clk     (xA_clk),
        .reset_     (reset_),
        .mode_25g   (mode_25g),
        .beat_valid (beat_valid)
    );

    lane_scan #(
        .DATA_WIDTH (DATA_WIDTH)
    ) lane_scan_i (
        .xA_clk              (xA_clk),
        .reset_              (reset_),
        .beat_valid          (beat_valid),
        .cgmii_rxd           (cgmii_rxd),
        .cgmii_rxc           (cgmii_rxc),
        .beat_sof_valid      (beat_sof_valid),
        .beat_sof_misaligned (beat_sof_misaligned),
        .beat_eof            (beat_eof)
    );

    frame_tracker frame_tracker_i (
        .xA_clk              (xA_clk),
        .reset_              (reset_),
        .beat_sof_valid      (beat_sof_valid),
        .beat_sof_misaligned (beat_sof_misaligned),
        .beat_eof            (beat_eof),
        .bad_frame           (bad_frame),
        .in_frame            (in_frame),
        .misaligned_sticky   (misaligned_sticky)
    );

    bad_frame_counter bad_frame_counter_i (
        .xA_clk            (xA_clk),
        .reset_            (reset_),
        .bad_frame         (bad_frame),
        .misaligned_sticky (misaligned_sticky),
        .fmac_rxd_en       (fmac_rxd_en),
        .rx_auto_clr       (rx_auto_clr),
        .bad_frame_reg     (bad_frame_reg)
    );

    //**********************************************************************
    // host register access
    //**********************************************************************
    reg_read_port #(
        .READ_LATENCY (READ_LATENCY)
    ) reg_read_port_i (
        .xA_clk            (xA_clk),
        .reset_            (reset_),
        .fmac_ctrl         (fmac_ctrl),
        .reg_rd_start      (reg_rd_start),
        .reg_addr          (reg_addr),
        .bad_frame_reg     (bad_frame_reg),
        .in_frame          (in_frame),
        .misaligned_sticky (misaligned_sticky),
        .rx_auto_clr       (rx_auto_clr),
        .reg_rd_done       (reg_rd_done),
        .reg_rdata         (reg_rdata)
    );

endmodule

// ==== tests/rx_frame_check_tb.sv ====
`timescale 1ns/100ps

module rx_frame_check_tb
    import cgmii_pkg::*;
    import mac_reg_pkg::*;
();

    localparam int DATA_WIDTH      = CGMII_DATA_W;
    localparam int LANES           = DATA_WIDTH / LANE_W;
    localparam int N_STEPS         = 14;
    localparam int RD_LAT          = 5;             // start to done, in clocks
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = N_STEPS * 40;
    localparam logic [REG_ADDR_W-1:0] ADDR_UNMAPPED = 16'h0048;

    // beat codes, one nibble per beat
    localparam logic [3:0] B_IDLE     = 4'd0;
    localparam logic [3:0] B_SOF      = 4'd1;      // start on a 4-lane boundary
    localparam logic [3:0] B_SOF_MIS  = 4'd2;      // start off the boundary
    localparam logic [3:0] B_TERM     = 4'd3;
    localparam logic [3:0] B_TERM_SOF = 4'd4;      // terminate and new start

    logic                  xA_clk;
    logic                  reset_;
    logic                  mode_25g;
    logic [DATA_WIDTH-1:0] cgmii_rxd;
    logic [LANES-1:0]      cgmii_rxc;
    logic                  fmac_rxd_en;
    logic [REG_DATA_W-1:0] fmac_ctrl;
    logic                  reg_rd_start;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic                  reg_rd_done;
    logic [REG_DATA_W-1:0] reg_rdata;

    string       step_name   [N_STEPS];
    logic        step_mode   [N_STEPS];
    logic        step_en     [N_STEPS];
    logic [31:0] step_ctrl   [N_STEPS];
    int          step_nbeats [N_STEPS];
    logic [31:0] step_beats  [N_STEPS];             // low nibble goes first

    logic                 m_open;                   // reference model state
    logic                 m_sticky;
    logic                 m_en;
    logic                 m_auto_clr;
    logic [BAD_CNT_W-1:0] m_cnt;
    logic [15:0]          lfsr;
    int                   checks;
    int                   data_errors;
    int                   hs_errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) clock_gen_i (
        .xA_clk (xA_clk),
        .reset_ (reset_)
    );

    rx_frame_check_top #(
        .DATA_WIDTH   (DATA_WIDTH),
        .READ_LATENCY (RD_LAT)
    ) rx_frame_check_top_i (
        .xA_clk       (xA_clk),
        .reset_       (reset_),
        .mode_25g     (mode_25g),
        .cgmii_rxd    (cgmii_rxd),
        .cgmii_rxc    (cgmii_rxc),
        .fmac_rxd_en  (fmac_rxd_en),
        .fmac_ctrl    (fmac_ctrl),
        .reg_rd_start (reg_rd_start),
        .reg_addr     (reg_addr),
        .reg_rd_done  (reg_rd_done),
        .reg_rdata    (reg_rdata)
    );

    //**********************************************************************
    // stimulus helpers
    //**********************************************************************
    function automatic int unsigned lfsr_bits(input int n);
        int unsigned val;
        logic        fb;
        val = 0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic set_step(input int i, input string name, input logic mode,
                            input logic en, input logic [31:0] ctrl, input int nb,
                            input logic [31:0] beats);
        step_name[i]   = name;
        step_mode[i]   = mode;
        step_en[i]     = en;
        step_ctrl[i]   = ctrl;
        step_nbeats[i] = nb;
        step_beats[i]  = beats;
    endtask

    task automatic drive_beat(input logic [3:0] code);
        int sof_lane;
        int term_lane;
        if (code == B_IDLE) begin
            for (int l = 0; l < LANES; l++) begin
                cgmii_rxd[l*LANE_W +: LANE_W] = 8'h07;
            end
            cgmii_rxc = '1;
        end else begin
            for (int l = 0; l < LANES; l++) begin
                cgmii_rxd[l*LANE_W +: LANE_W] = 8'(lfsr_bits(LANE_W));  // frame data
            end
            cgmii_rxc = '0;
            sof_lane  = int'(lfsr_bits(3)) * SOF_ALIGN;
            if (code == B_SOF_MIS) begin
                sof_lane = sof_lane + 1 + int'(lfsr_bits(2)) % 3;
            end
            term_lane = int'(lfsr_bits(5));
            if (term_lane == sof_lane) begin
                term_lane = term_lane ^ 1;              // keep the two lanes apart
            end
            if (code == B_SOF || code == B_SOF_MIS || code == B_TERM_SOF) begin
                cgmii_rxd[sof_lane*LANE_W +: LANE_W] = CHAR_START;
                cgmii_rxc[sof_lane] = 1'b1;
            end
            if (code == B_TERM || code == B_TERM_SOF) begin
                cgmii_rxd[term_lane*LANE_W +: LANE_W] = CHAR_TERM;
                cgmii_rxc[term_lane] = 1'b1;
            end
        end
    endtask

    // framing rules applied to one sampled beat
    task automatic model_beat(input logic [3:0] code);
        logic sof_ok;
        logic sof_bad;
        logic eof;
        logic bad;
        sof_ok  = (code == B_SOF) || (code == B_TERM_SOF);
        sof_bad = (code == B_SOF_MIS);
        eof     = (code == B_TERM) || (code == B_TERM_SOF);
        bad     = (eof && !m_open) || ((sof_ok || sof_bad) && m_open && !eof);
        if (sof_ok) begin
            m_open = 1'b1;
        end else if (eof) begin
            m_open = 1'b0;
        end
        if (sof_bad) begin
            m_sticky = 1'b1;
        end
        if (bad && m_en) begin
            m_cnt = m_cnt + 1'b1;
        end
    endtask

    task automatic run_step(input int i);
        int hold;
        @(negedge xA_clk);
        mode_25g    = step_mode[i];
        fmac_rxd_en = step_en[i];
        fmac_ctrl   = step_ctrl[i];
        drive_beat(B_IDLE);
        repeat (4) @(negedge xA_clk);               // mode and enable settle
        hold       = step_mode[i] ? 4 : 1;          // 25G holds each beat four clocks
        m_en       = step_en[i];
        m_auto_clr = step_ctrl[i][CTRL_RX_AUTO_CLR_BIT];
        if (!m_en) begin
            m_cnt = '0;
        end
        for (int b = 0; b < step_nbeats[i]; b++) begin
            drive_beat(step_beats[i][b*4 +: 4]);
            model_beat(step_beats[i][b*4 +: 4]);
            repeat (hold) @(negedge xA_clk);
        end
        drive_beat(B_IDLE);
        repeat (8) @(negedge xA_clk);
    endtask

    //**********************************************************************
    // three back to back reads, done expected RD_LAT clocks after each start
    //**********************************************************************
    task automatic read_regs(input int i);
        logic [REG_ADDR_W-1:0] addr        [3];
        logic [REG_DATA_W-1:0] expect_data [3];
        string                 reg_name    [3];
        addr[0]        = ADDR_BAD_FRAME_CNT;
        addr[1]        = ADDR_RX_STATUS;
        addr[2]        = ADDR_UNMAPPED;
        reg_name[0]    = "bad_frame_cnt";
        reg_name[1]    = "rx_status";
        reg_name[2]    = "unmapped";
        expect_data[0] = (m_en && !m_auto_clr) ? {m_sticky, m_cnt} : '0;
        expect_data[1] = {{(REG_DATA_W-2){1'b0}}, m_sticky, m_open};
        expect_data[2] = '0;
        for (int t = 0; t < 3 + RD_LAT + 2; t++) begin
            if (reg_rd_done) begin
                if (t < RD_LAT || t >= RD_LAT + 3) begin
                    hs_errors++;
                    $display("%s: reg_rd_done came %0d cycles after the first read start",
                             step_name[i], t);
                end else begin
                    checks++;
                    if (reg_rdata !== expect_data[t-RD_LAT]) begin
                        data_errors++;
                        $display("error %s %s: expected %08h actual %08h", step_name[i],
                                 reg_name[t-RD_LAT], expect_data[t-RD_LAT], reg_rdata);
                    end
                end
            end else if (t >= RD_LAT && t < RD_LAT + 3) begin
                hs_errors++;
                $display("%s: no reg_rd_done %0d cycles after the read of %s",
                         step_name[i], RD_LAT, reg_name[t-RD_LAT]);
            end
            if (t < 3) begin
                reg_rd_start = 1'b1;
                reg_addr     = addr[t];
            end else begin
                reg_rd_start = 1'b0;
                reg_addr     = '0;
            end
            @(negedge xA_clk);
        end
    endtask

    //**********************************************************************
    // main sequence
    //**********************************************************************
    initial begin
        lfsr         = 16'd35137;
        checks       = 0;
        data_errors  = 0;
        hs_errors    = 0;
        mode_25g     = 1'b0;
        fmac_rxd_en  = 1'b0;
        fmac_ctrl    = '0;
        reg_rd_start = 1'b0;
        reg_addr     = '0;
        m_open       = 1'b0;
        m_sticky     = 1'b0;
        m_en         = 1'b0;
        m_auto_clr   = 1'b0;
        m_cnt        = '0;
        drive_beat(B_IDLE);
        set_step(0,  "after_reset",         1'b0, 1'b1, 32'h00, 0, 32'h0);
        set_step(1,  "good_frames",         1'b0, 1'b1, 32'h00, 5, 32'h34131);
        set_step(2,  "term_no_start",       1'b0, 1'b1, 32'h00, 3, 32'h313);
        set_step(3,  "double_start",        1'b0, 1'b1, 32'h00, 3, 32'h311);
        set_step(4,  "misaligned_start",    1'b0, 1'b1, 32'h00, 3, 32'h312);
        set_step(5,  "rxd_en_off",          1'b0, 1'b0, 32'h00, 1, 32'h3);
        set_step(6,  "count_restart",       1'b0, 1'b1, 32'h00, 2, 32'h33);
        set_step(7,  "auto_clear",          1'b0, 1'b1, 32'h80, 1, 32'h3);
        set_step(8,  "auto_clear_off",      1'b0, 1'b1, 32'h00, 0, 32'h0);
        set_step(9,  "rate_25g_bad",        1'b1, 1'b1, 32'h00, 4, 32'h3113);
        set_step(10, "rate_25g_good",       1'b1, 1'b1, 32'h00, 4, 32'h4131);
        set_step(11, "full_rate_close",     1'b0, 1'b1, 32'h00, 1, 32'h3);
        set_step(12, "open_at_read",        1'b0, 1'b1, 32'h00, 1, 32'h1);
        set_step(13, "misaligned_in_frame", 1'b0, 1'b1, 32'h00, 2, 32'h32);
        @(posedge reset_);
        for (int i = 0; i < N_STEPS; i++) begin
            run_step(i);
            read_regs(i);
        end
        $display("checks %0d, data errors %0d, handshake errors %0d",
                 checks, data_errors, hs_errors);
        if (data_errors + hs_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic xA_clk,
    output logic reset_
);

    initial begin
        xA_clk = 1'b0;
        forever #(PERIOD/2) xA_clk = ~xA_clk;
    end

    initial begin
        reset_ = 1'b0;
        repeat (RESET_CYCLES) @(posedge xA_clk);
        @(negedge xA_clk);
        reset_ = 1'b1;                              // released away from the rising edge
    end

endmodule
